//--- ecc_mem_pkg.sv
`default_nettype none

package ecc_mem_pkg;

    localparam int mem_data_w = 58;
    localparam int mem_par_w  = 8;
    localparam int mem_cw_w   = mem_data_w + mem_par_w;
    localparam int mem_depth  = 64;
    localparam int mem_addr_w = $clog2(mem_depth);
    localparam int cnt_w      = 16;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_resp,
        st_wait_low
    } ctrl_state_e;

    // data sits in the upper bits so that a flip mask lines up with {data, parity}
    typedef struct packed {
        logic [mem_data_w-1:0] data;
        logic [mem_par_w-1:0]  parity;
    } codeword_t;

    typedef struct packed {
        mem_op_e               op;
        logic [mem_addr_w-1:0] addr;
        logic [mem_data_w-1:0] wdata;
        logic [mem_cw_w-1:0]   flip;
    } mem_req_t;

    typedef struct packed {
        logic [mem_data_w-1:0] rdata;
        logic                  sbit_err;
        logic                  dbit_err;
    } mem_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic                  sbit;
        logic                  dbit;
        logic [mem_addr_w-1:0] addr;
    } err_evt_t;

endpackage

`default_nettype wire

//--- ecc_58_cal.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_58_cal #(
    parameter int DATA_WIDTH   = 58,
    parameter int PARITY_WIDTH = 8
) (
    input  wire  [DATA_WIDTH-1:0]   data_in,
    output logic [DATA_WIDTH-1:0]   data_out,
    input  wire  [PARITY_WIDTH-1:0] parity_in,
    output logic [PARITY_WIDTH-1:0] parity_out,
    input  wire                     bypass,
    output logic [DATA_WIDTH-1:0]   mask,
    output logic                    sbit_err,
    output logic                    dbit_err
);

    // column of the check matrix for one data bit
    // the low bits follow the Hamming positions that are not powers of two,
    // the last data bit takes the spare check bit, and the top bit makes
    // every column odd weight so double errors never alias a single error
    function automatic logic [PARITY_WIDTH-1:0] h_col(input int idx);
        logic [PARITY_WIDTH-1:0] col;
        int                      cnt;
        col = '0;
        cnt = 0;
        if (idx == DATA_WIDTH - 1) begin
            col[PARITY_WIDTH-2] = 1'b1;
            col[0]              = 1'b1;
        end else begin
            for (int pos = 3; pos < 2 ** (PARITY_WIDTH - 2); pos++) begin
                if ((pos & (pos - 1)) != 0) begin
                    if (cnt == idx) begin
                        col[PARITY_WIDTH-3:0] = pos[PARITY_WIDTH-3:0];
                    end
                    cnt++;
                end
            end
        end
        col[PARITY_WIDTH-1] = ~^col[PARITY_WIDTH-2:0];
        return col;
    endfunction

    function automatic logic [DATA_WIDTH*PARITY_WIDTH-1:0] build_h();
        logic [DATA_WIDTH*PARITY_WIDTH-1:0] h;
        h = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            h[i*PARITY_WIDTH +: PARITY_WIDTH] = h_col(i);
        end
        return h;
    endfunction

    localparam logic [DATA_WIDTH*PARITY_WIDTH-1:0] h_cols = build_h();

    logic [PARITY_WIDTH-1:0] syndrome;
    logic                    check_bit_err;
    logic                    single_err;
    logic                    double_err;

    always_comb begin
        parity_out = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (data_in[i]) begin
                parity_out = parity_out ^ h_cols[i*PARITY_WIDTH +: PARITY_WIDTH];
            end
        end
    end

    assign syndrome = parity_in ^ parity_out;

    // columns are distinct, so at most one mask bit can match
    always_comb begin
        mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (syndrome == h_cols[i*PARITY_WIDTH +: PARITY_WIDTH]) begin
                mask[i] = 1'b1;
            end
        end
    end

    // a weight-one syndrome points at a check bit and leaves the data good
    assign check_bit_err = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);
    assign single_err    = (|mask) || check_bit_err;
    assign double_err    = (syndrome != '0) && !single_err;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : single_err;
    assign dbit_err = bypass ? 1'b0 : double_err;

endmodule

`default_nettype wire

//--- ecc_mem_array.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_array
    import ecc_mem_pkg::*;
(
    input  wire                  clk,
    input  wire                  en,
    input  wire                  we,
    input  wire [mem_addr_w-1:0] addr,
    input  wire codeword_t       wcw,
    output codeword_t            rcw
);

    codeword_t mem [mem_depth];

    // a write leaves rcw holding the last read word
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wcw;
            end else begin
                rcw <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- ecc_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_ctrl
    import ecc_mem_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   req,
    input  wire mem_req_t         req_data,
    input  wire                   bypass,
    output logic                  ack,
    output mem_rsp_t              rsp,
    output logic                  mem_en,
    output logic                  mem_we,
    output logic [mem_addr_w-1:0] mem_addr,
    output codeword_t             mem_wcw,
    input  wire codeword_t        mem_rcw,
    output err_evt_t              evt
);

    ctrl_state_e           state;
    logic                  start;
    logic [mem_addr_w-1:0] addr_q;
    logic [mem_data_w-1:0] cal_data_in;
    logic [mem_par_w-1:0]  cal_par_in;
    logic [mem_data_w-1:0] cal_data_out;
    logic [mem_par_w-1:0]  cal_par_out;
    logic                  cal_sbit;
    logic                  cal_dbit;

    // the request is taken in the same cycle it is seen in idle
    assign start    = (state == st_idle) && req;
    assign mem_en   = start;
    assign mem_we   = start && (req_data.op == op_write);
    assign mem_addr = req_data.addr;

    // flip goes on after encoding so the stored word carries the injected error
    assign mem_wcw = codeword_t'({req_data.wdata, cal_par_out} ^ req_data.flip);

    // one checker encodes in idle and checks the stored word in st_read
    always_comb begin
        if (state == st_read) begin
            cal_data_in = mem_rcw.data;
            cal_par_in  = mem_rcw.parity;
        end else begin
            cal_data_in = req_data.wdata;
            cal_par_in  = '0;
        end
    end

    ecc_58_cal #(
        .DATA_WIDTH   (mem_data_w),
        .PARITY_WIDTH (mem_par_w)
    ) u_ecc_cal (
        .data_in    (cal_data_in),
        .data_out   (cal_data_out),
        .parity_in  (cal_par_in),
        .parity_out (cal_par_out),
        .bypass     (bypass),
        .mask       (),
        .sbit_err   (cal_sbit),
        .dbit_err   (cal_dbit)
    );

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= req_data.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            ack   <= 1'b0;
            rsp   <= '0;
            evt   <= '0;
        end else begin
            evt.valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= (req_data.op == op_write) ? st_resp : st_read;
                    end
                end
                st_read: begin
                    rsp.rdata    <= cal_data_out;
                    rsp.sbit_err <= cal_sbit;
                    rsp.dbit_err <= cal_dbit;
                    evt.valid    <= 1'b1;
                    evt.sbit     <= cal_sbit;
                    evt.dbit     <= cal_dbit;
                    evt.addr     <= addr_q;
                    ack          <= 1'b1;
                    state        <= st_wait_low;
                end
                // writes leave rsp with the last read result
                st_resp: begin
                    ack   <= 1'b1;
                    state <= st_wait_low;
                end
                st_wait_low: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ecc_err_log.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_err_log
    import ecc_mem_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire err_evt_t         evt,
    output logic [cnt_w-1:0]      ce_count,
    output logic [cnt_w-1:0]      ue_count,
    output logic [mem_addr_w-1:0] last_err_addr
);

    // counters stick at all ones rather than wrap
    function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] cnt);
        if (cnt == '1) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ce_count      <= '0;
            ue_count      <= '0;
            last_err_addr <= '0;
        end else if (evt.valid) begin
            if (evt.sbit) begin
                ce_count <= sat_inc(ce_count);
            end
            if (evt.dbit) begin
                ue_count <= sat_inc(ue_count);
            end
            if (evt.sbit || evt.dbit) begin
                last_err_addr <= evt.addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- ecc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top
    import ecc_mem_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   req,
    input  wire mem_req_t         req_data,
    input  wire                   bypass,
    output logic                  ack,
    output mem_rsp_t              rsp,
    output logic [cnt_w-1:0]      ce_count,
    output logic [cnt_w-1:0]      ue_count,
    output logic [mem_addr_w-1:0] last_err_addr
);

    logic                  mem_en;
    logic                  mem_we;
    logic [mem_addr_w-1:0] mem_addr;
    codeword_t             mem_wcw;
    codeword_t             mem_rcw;
    err_evt_t              evt;

    ecc_mem_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .bypass   (bypass),
        .ack      (ack),
        .rsp      (rsp),
        .mem_en   (mem_en),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wcw  (mem_wcw),
        .mem_rcw  (mem_rcw),
        .evt      (evt)
    );

    ecc_mem_array u_array (
        .clk  (clk),
        .en   (mem_en),
        .we   (mem_we),
        .addr (mem_addr),
        .wcw  (mem_wcw),
        .rcw  (mem_rcw)
    );

    ecc_err_log u_err_log (
        .clk           (clk),
        .rst           (rst),
        .evt           (evt),
        .ce_count      (ce_count),
        .ue_count      (ue_count),
        .last_err_addr (last_err_addr)
    );

endmodule

`default_nettype wire

//--- ecc_mem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_sva
    import ecc_mem_pkg::*;
(
    input wire           clk,
    input wire           rst,
    input wire           req,
    input wire mem_req_t req_data,
    input wire           ack,
    input wire mem_rsp_t rsp
);

    // ack may only answer a request that was up on the edge before
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req)
    ) else $error("ack rose without a request");

    // the client holds its request fields until it drops req
    req_data_stable: assert property (
        @(posedge clk) disable iff (rst) (req && $past(req)) |-> $stable(req_data)
    ) else $error("req_data changed while req was high");

    flags_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(rsp.sbit_err && rsp.dbit_err)
    ) else $error("sbit_err and dbit_err both set");

endmodule

bind ecc_mem_ctrl ecc_mem_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
);

`default_nettype wire

//--- tb_ecc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_mem_top
    import ecc_mem_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 2;
    localparam int hold_cycles  = 40;
    localparam int ack_limit    = 20;
    localparam int xfer_count   = 60;
    localparam int xfer_cycles  = 6;
    localparam int watchdog_ns  =
        (reset_cycles + xfer_count * xfer_cycles + hold_cycles + 8) * clk_period + 400;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic                  bypass;
    mem_req_t              req_data;
    logic                  ack;
    mem_rsp_t              rsp;
    logic [cnt_w-1:0]      ce_count;
    logic [cnt_w-1:0]      ue_count;
    logic [mem_addr_w-1:0] last_err_addr;

    // reference model of what each address should hold and how it was corrupted
    logic [mem_data_w-1:0] data_shadow [mem_depth];
    logic [mem_cw_w-1:0]   flip_shadow [mem_depth];
    logic [cnt_w-1:0]      exp_ce;
    logic [cnt_w-1:0]      exp_ue;
    logic [mem_addr_w-1:0] exp_last_addr;

    integer seed;
    int     test_errs;
    int     total_errs;
    int     tests_run;
    int     tests_failed;
    int     checks;
    int     data_bits [6] = '{0, 1, 17, 31, 44, 57};

    ecc_mem_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_data      (req_data),
        .bypass        (bypass),
        .ack           (ack),
        .rsp           (rsp),
        .ce_count      (ce_count),
        .ue_count      (ue_count),
        .last_err_addr (last_err_addr)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, a test never finished", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [mem_data_w-1:0] random_data();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        r_hi = $random(seed);
        r_lo = $random(seed);
        return {r_hi[mem_data_w-33:0], r_lo};
    endfunction

    function automatic int flip_weight(input logic [mem_cw_w-1:0] flip);
        return $countones(flip);
    endfunction

    task automatic compare(input string name, input string what,
                           input logic [mem_cw_w-1:0] exp, input logic [mem_cw_w-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("error %s %s: expected %h actual %h", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    // waits for ack to reach level, giving up after ack_limit cycles
    task automatic wait_for_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < ack_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack !== level) begin
            $display("handshake stuck, ack did not go to %0b within %0d cycles", level, ack_limit);
            test_errs++;
        end
    endtask

    task automatic write_word(input logic [mem_addr_w-1:0] addr,
                              input logic [mem_data_w-1:0] data,
                              input logic [mem_cw_w-1:0] flip);
        req_data.op    = op_write;
        req_data.addr  = addr;
        req_data.wdata = data;
        req_data.flip  = flip;
        req = 1'b1;
        wait_for_ack(1'b1);
        req = 1'b0;
        wait_for_ack(1'b0);
        data_shadow[addr] = data;
        flip_shadow[addr] = flip;
    endtask

    task automatic read_word(input logic [mem_addr_w-1:0] addr, output mem_rsp_t got);
        req_data.op    = op_read;
        req_data.addr  = addr;
        req_data.wdata = '0;
        req_data.flip  = '0;
        req = 1'b1;
        wait_for_ack(1'b1);
        got = rsp;
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic read_and_check(input string name, input logic [mem_addr_w-1:0] addr);
        mem_rsp_t got;
        int       weight;
        logic     exp_sbit;
        logic     exp_dbit;
        weight   = flip_weight(flip_shadow[addr]);
        exp_sbit = !bypass && (weight == 1);
        exp_dbit = !bypass && (weight == 2);
        read_word(addr, got);
        // bypass hands back the stored data bits as they are
        if (bypass) begin
            compare(name, "rdata",
                    data_shadow[addr] ^ flip_shadow[addr][mem_cw_w-1:mem_par_w], got.rdata);
        end else if (weight < 2) begin
            compare(name, "rdata", data_shadow[addr], got.rdata);
        end
        compare(name, "sbit_err", exp_sbit, got.sbit_err);
        compare(name, "dbit_err", exp_dbit, got.dbit_err);
        if (exp_sbit) begin
            exp_ce = exp_ce + 1'b1;
        end
        if (exp_dbit) begin
            exp_ue = exp_ue + 1'b1;
        end
        if (exp_sbit || exp_dbit) begin
            exp_last_addr = addr;
        end
        compare(name, "ce_count", exp_ce, ce_count);
        compare(name, "ue_count", exp_ue, ue_count);
        compare(name, "last_err_addr", exp_last_addr, last_err_addr);
    endtask

    task automatic clean_readback();
        logic [31:0]           r;
        logic [mem_addr_w-1:0] addr;
        compare("clean", "ack after reset", 1'b0, ack);
        compare("clean", "rsp after reset", '0, rsp);
        for (int i = 0; i < 16; i++) begin
            r    = $random(seed);
            addr = r[mem_addr_w-1:0];
            write_word(addr, random_data(), '0);
            read_and_check("clean", addr);
        end
        compare("clean", "ce_count", '0, ce_count);
        compare("clean", "ue_count", '0, ue_count);
        finish_test("clean");
    endtask

    task automatic single_bit_errors();
        logic [mem_cw_w-1:0] flip;
        for (int i = 0; i < 6; i++) begin
            flip = '0;
            flip[mem_par_w + data_bits[i]] = 1'b1;
            write_word(mem_addr_w'(i + 1), random_data(), flip);
            read_and_check("single_bit", mem_addr_w'(i + 1));
        end
        // check bits sit in the low byte of the codeword
        write_word(6'd10, random_data(), mem_cw_w'(1) << 0);
        read_and_check("single_bit", 6'd10);
        write_word(6'd11, random_data(), mem_cw_w'(1) << 7);
        read_and_check("single_bit", 6'd11);
        finish_test("single_bit");
    endtask

    task automatic double_bit_errors();
        write_word(6'd40, random_data(), (mem_cw_w'(1) << 11) | (mem_cw_w'(1) << 58));
        read_and_check("double_bit", 6'd40);
        write_word(6'd41, random_data(), (mem_cw_w'(1) << 17) | (mem_cw_w'(1) << 2));
        read_and_check("double_bit", 6'd41);
        write_word(6'd42, random_data(), (mem_cw_w'(1) << 1) | (mem_cw_w'(1) << 6));
        read_and_check("double_bit", 6'd42);
        finish_test("double_bit");
    endtask

    task automatic bypass_raw();
        write_word(6'd50, random_data(), mem_cw_w'(1) << 20);
        write_word(6'd51, random_data(), (mem_cw_w'(1) << 30) | (mem_cw_w'(1) << 65));
        bypass = 1'b1;
        read_and_check("bypass", 6'd50);
        read_and_check("bypass", 6'd51);
        bypass = 1'b0;
        // same word read normally is corrected again
        read_and_check("bypass", 6'd50);
        finish_test("bypass");
    endtask

    task automatic held_request();
        mem_rsp_t held;
        write_word(6'd21, random_data(), '0);
        req_data.op    = op_read;
        req_data.addr  = 6'd21;
        req_data.wdata = '0;
        req_data.flip  = '0;
        req = 1'b1;
        @(posedge clk);
        #1;
        compare("held_req", "ack after edge 0", 1'b0, ack);
        @(posedge clk);
        #1;
        compare("held_req", "ack after edge 1", 1'b1, ack);
        compare("held_req", "rdata", data_shadow[21], rsp.rdata);
        held = rsp;
        repeat (hold_cycles) begin
            @(posedge clk);
            #1;
            compare("held_req", "ack while held", 1'b1, ack);
            compare("held_req", "rsp while held", held, rsp);
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        compare("held_req", "ack after req sampled low", 1'b0, ack);
        compare("held_req", "rsp after release", held, rsp);
        finish_test("held_req");
    endtask

    initial begin
        seed          = 32'hd11f_16b7;
        clk           = 1'b0;
        rst           = 1'b1;
        req           = 1'b0;
        bypass        = 1'b0;
        req_data      = '0;
        exp_ce        = '0;
        exp_ue        = '0;
        exp_last_addr = '0;
        test_errs     = 0;
        total_errs    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        checks        = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        clean_readback();
        single_bit_errors();
        double_bit_errors();
        bypass_raw();
        held_request();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ecc_mem_top.f
ecc_mem_pkg.sv
ecc_58_cal.sv
ecc_mem_array.sv
ecc_mem_ctrl.sv
ecc_err_log.sv
ecc_mem_top.sv
ecc_mem_sva.sv
tb_ecc_mem_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timing -Wno-fatal --top-module tb_ecc_mem_top \
    -f ecc_mem_top.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
